// File: Bender.yml
package:
  name: heap_alloc

sources:
  - heap_pkg.sv
  - heap_cmd_if.sv
  - heap_mem_if.sv
  - heap_decode.sv
  - heap_alloc.sv
  - heap_store.sv
  - heap_top.sv
  - target: test
    files:
      - heap_checker.sv
      - tb_heap.sv

// File: heap_alloc.sv
/*
 * heap allocation stage
 * keeps heap top, free-list head, free count and the sticky error,
 * picks the cell for each request and drives the store commands
 */

`timescale 1ns/1ps
`default_nettype none

module heap_alloc (
    input  wire             i_clk,                  // domain clock
    input  wire             i_reset,                // sync reset, active high

    heap_cmd_if.dst         i_cmd,                  // from decode stage
    heap_mem_if.ctl         o_mem,                  // to cell store

    output heap_pkg::word_t o_addr,                 // allocated pointer
    output logic            o_err                   // sticky error, heap halted
);

    heap_pkg::word_t             mem_top;           // next fresh cell, tagged
    heap_pkg::word_t             mem_next;          // free-list head, tagged or NIL
    heap_pkg::index_t            mem_free;          // cells on the free-list
    logic [heap_pkg::ADDR_SZ:0]  next_top;          // extra bit for overflow
    logic                        free_f;            // free-list has a cell
    heap_pkg::index_t            top_idx;
    heap_pkg::index_t            head_idx;

    assign top_idx  = mem_top[heap_pkg::ADDR_SZ-1:0];
    assign head_idx = mem_next[heap_pkg::ADDR_SZ-1:0];
    assign next_top = {1'b0, top_idx} + 1'b1;
    assign free_f   = (mem_next & heap_pkg::MUT_TAG) != '0;  // NIL has no MUT_TAG

    // store commands, combinational so they land on the next edge
    always_comb begin
        o_mem.we       = 1'b0;
        o_mem.widx     = i_cmd.waddr;
        o_mem.wdata    = i_cmd.wdata;
        o_mem.re       = 1'b0;
        o_mem.ridx     = i_cmd.raddr;
        o_mem.link_idx = head_idx;                  // link of head always visible
        if (!o_err) begin
            case (i_cmd.op)
                heap_pkg::OP_ALLOC: begin
                    o_mem.we    = 1'b1;
                    o_mem.widx  = free_f ? head_idx : top_idx;
                    o_mem.wdata = i_cmd.data;
                end
                heap_pkg::OP_FREE: begin
                    o_mem.we    = 1'b1;
                    o_mem.widx  = i_cmd.addr[heap_pkg::ADDR_SZ-1:0];
                    o_mem.wdata = mem_next;         // old head becomes the link
                end
                heap_pkg::OP_PASS: begin
                    o_mem.we    = 1'b1;
                    o_mem.widx  = i_cmd.addr[heap_pkg::ADDR_SZ-1:0];
                    o_mem.wdata = i_cmd.data;
                end
                heap_pkg::OP_WRITE: o_mem.we = 1'b1;
                heap_pkg::OP_READ:  o_mem.re = 1'b1;
                heap_pkg::OP_RW: begin
                    o_mem.we = 1'b1;
                    o_mem.re = 1'b1;                // read sees the old value
                end
                default: ;                          // idle or conflict
            endcase
        end
    end

    // heap state and result
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_addr   <= heap_pkg::UNDEF;
            o_err    <= 1'b0;
            mem_top  <= heap_pkg::HEAP_BASE;        // index 0
            mem_next <= heap_pkg::NIL;
            mem_free <= '0;
        end else begin
            o_addr <= heap_pkg::UNDEF;              // no alloc this cycle
            if (!o_err) begin
                case (i_cmd.op)
                    heap_pkg::OP_ALLOC: begin
                        if (free_f) begin
                            o_addr   <= mem_next;   // reuse newest freed cell
                            mem_next <= o_mem.link_data;  // pop
                            mem_free <= mem_free - 1'b1;
                        end else begin
                            o_addr <= mem_top;
                            if (next_top[heap_pkg::ADDR_SZ]) begin
                                o_err <= 1'b1;      // out of heap
                            end else begin
                                mem_top <= {mem_top[heap_pkg::DATA_SZ-1:heap_pkg::ADDR_SZ],
                                            next_top[heap_pkg::ADDR_SZ-1:0]};
                            end
                        end
                    end
                    heap_pkg::OP_FREE: begin
                        mem_next <= i_cmd.addr;     // push
                        mem_free <= mem_free + 1'b1;
                    end
                    heap_pkg::OP_PASS: o_addr <= i_cmd.addr;
                    heap_pkg::OP_CONFLICT: o_err <= 1'b1;
                    default: ;                      // memory ops go to the store
                endcase
            end
        end
    end

    // count and head must agree on an empty list
    a_free_cnt : assert property (
        @(posedge i_clk) disable iff (i_reset)
        (mem_free == '0) == (mem_next == heap_pkg::NIL)
    ) else $error("heap_alloc: free count and free-list head disagree");

    // halted heap leaves the store alone
    a_halt_nowr : assert property (
        @(posedge i_clk) disable iff (i_reset)
        o_err |-> !o_mem.we
    ) else $error("heap_alloc: store written after error");

endmodule

`default_nettype wire

// File: heap_checker.sv
/*
 * heap checker
 * reference model of the heap allocator fed from the DUT strobes
 * compares o_addr, o_rdata and o_err two edges after each request
 */

`timescale 1ns/1ps
`default_nettype none

module heap_checker (
    input  wire             i_clk,
    input  wire             i_reset,
    input  wire             i_alloc,
    input  heap_pkg::word_t i_data,
    input  wire             i_free,
    input  heap_pkg::word_t i_addr,
    input  wire             i_wr,
    input  heap_pkg::word_t i_waddr,
    input  heap_pkg::word_t i_wdata,
    input  wire             i_rd,
    input  heap_pkg::word_t i_raddr,
    input  heap_pkg::word_t i_ret_addr,             // DUT o_addr
    input  heap_pkg::word_t i_rdata,                // DUT o_rdata
    input  wire             i_err,                  // DUT o_err
    output int              o_issued,               // busy requests sampled
    output int              o_done,                 // busy requests compared
    output int              o_errors                // mismatches so far
);

    typedef struct {
        logic            valid;                     // slot holds an expectation
        logic            busy;                      // request had a strobe
        heap_pkg::word_t addr;
        logic            err;
        heap_pkg::word_t rdata;
        logic            rknown;                    // rdata worth comparing
    } expect_t;

    heap_pkg::word_t shadow  [heap_pkg::MEM_MAX];   // per-cell copy
    logic            cell_ok [heap_pkg::MEM_MAX];   // cell holds known data
    heap_pkg::word_t free_q  [$];                   // free-list with newest at back
    int              next_idx;                      // heap top as an index
    logic            halted;                        // sticky error
    heap_pkg::word_t last_rdata;
    logic            last_known;
    expect_t         exp1;                          // request from last edge
    expect_t         exp2;                          // request from two edges ago
    int              errs;

    initial begin
        for (int i = 0; i < heap_pkg::MEM_MAX; i++) begin
            cell_ok[i] = 1'b0;
        end
        exp1.valid = 1'b0;
        exp2.valid = 1'b0;
        next_idx   = 0;
        halted     = 1'b0;
        last_rdata = heap_pkg::UNDEF;
        last_known = 1'b0;
        errs       = 0;
        o_issued   = 0;
        o_done     = 0;
        o_errors   = 0;
    end

    // model steps on the edge where the DUT samples the strobes
    always @(posedge i_clk) begin : model
        heap_pkg::word_t ptr;
        heap_pkg::index_t idx;
        exp2 = exp1;                                // age by one edge
        ptr  = heap_pkg::UNDEF;
        if (i_reset) begin
            exp2.addr = heap_pkg::UNDEF;            // reset clears the result registers
            exp2.err  = 1'b0;
            next_idx = 0;
            free_q.delete();
            halted = 1'b0;                          // cells keep their data
        end else if (!halted) begin
            if ((i_alloc || i_free) && (i_wr || i_rd)) begin
                halted = 1'b1;                      // both ports at once
            end else if (i_alloc) begin
                if (i_free) begin
                    ptr = i_addr;                   // freed cell handed straight back
                end else if (free_q.size() > 0) begin
                    ptr = free_q.pop_back();        // newest freed cell first
                end else begin
                    ptr = heap_pkg::HEAP_BASE | heap_pkg::word_t'(next_idx);
                    if (next_idx == heap_pkg::MEM_MAX - 1) begin
                        halted = 1'b1;              // last cell exhausts the heap
                    end else begin
                        next_idx++;
                    end
                end
                idx = ptr[heap_pkg::ADDR_SZ-1:0];
                shadow[idx]  = i_data;
                cell_ok[idx] = 1'b1;
            end else if (i_free) begin
                free_q.push_back(i_addr);
                cell_ok[i_addr[heap_pkg::ADDR_SZ-1:0]] = 1'b0;  // now holds a link
            end else begin
                if (i_rd) begin                     // read sees the value before the write
                    last_rdata = shadow[i_raddr[heap_pkg::ADDR_SZ-1:0]];
                    last_known = cell_ok[i_raddr[heap_pkg::ADDR_SZ-1:0]];
                end
                if (i_wr) begin
                    shadow[i_waddr[heap_pkg::ADDR_SZ-1:0]]  = i_wdata;
                    cell_ok[i_waddr[heap_pkg::ADDR_SZ-1:0]] = 1'b1;
                end
            end
        end
        exp1.valid  = 1'b1;
        exp1.busy   = !i_reset && (i_alloc || i_free || i_wr || i_rd);
        exp1.addr   = ptr;                          // UNDEF when nothing allocated
        exp1.err    = halted;
        exp1.rdata  = last_rdata;                   // held between reads
        exp1.rknown = last_known;
        if (exp1.busy) begin
            o_issued <= o_issued + 1;
        end
    end

    // outputs settled since the rising edge
    always @(negedge i_clk) begin
        if (exp2.valid) begin
            if (i_ret_addr !== exp2.addr) begin
                $display("Fail at %0t ns: o_addr is %h, expected %h",
                         $time, i_ret_addr, exp2.addr);
                errs++;
            end
            if (i_err !== exp2.err) begin
                $display("Fail at %0t ns: o_err is %b, expected %b", $time, i_err, exp2.err);
                errs++;
            end
            if (exp2.rknown && (i_rdata !== exp2.rdata)) begin
                $display("Fail at %0t ns: o_rdata is %h, expected %h",
                         $time, i_rdata, exp2.rdata);
                errs++;
            end
            if (exp2.busy) begin
                o_done <= o_done + 1;
            end
        end
        o_errors <= errs;
    end

endmodule

`default_nettype wire

// File: heap_cmd_if.sv
/*
 * heap command bus
 * decoded request from the decode stage to the allocation stage,
 * one new opcode every cycle and no handshake
 */

`timescale 1ns/1ps
`default_nettype none

interface heap_cmd_if;

    heap_pkg::heap_op_e op;                         // stage opcode
    heap_pkg::word_t    data;                       // alloc initial data
    heap_pkg::word_t    addr;                       // pointer being freed
    heap_pkg::index_t   waddr;                      // write cell
    heap_pkg::word_t    wdata;                      // write data
    heap_pkg::index_t   raddr;                      // read cell

    modport src (output op, data, addr, waddr, wdata, raddr);
    modport dst (input  op, data, addr, waddr, wdata, raddr);

endinterface

`default_nettype wire

// File: heap_decode.sv
/*
 * heap decode stage
 * samples the pointer and memory strobes, folds them into one
 * opcode per cycle and registers it with its operands
 */

`timescale 1ns/1ps
`default_nettype none

module heap_decode (
    input  wire             i_clk,                  // domain clock
    input  wire             i_reset,                // synchronous active-high reset

    input  wire             i_alloc,                // alloc request
    input  heap_pkg::word_t i_data,                 // initial data
    input  wire             i_free,                 // free request
    input  heap_pkg::word_t i_addr,                 // pointer to free

    input  wire             i_wr,                   // write request
    input  heap_pkg::word_t i_waddr,                // write pointer
    input  heap_pkg::word_t i_wdata,                // write data
    input  wire             i_rd,                   // read request
    input  heap_pkg::word_t i_raddr,                // read pointer

    heap_cmd_if.src         o_cmd                   // to allocation stage
);

    logic               ptr_req;                    // pointer port busy
    logic               mem_req;                    // memory port busy
    heap_pkg::heap_op_e op_nxt;                     // classified request

    assign ptr_req = i_alloc | i_free;
    assign mem_req = i_wr | i_rd;

    // both ports at once is a conflict
    always_comb begin
        if (ptr_req && mem_req) begin
            op_nxt = heap_pkg::OP_CONFLICT;
        end else if (i_alloc && i_free) begin
            op_nxt = heap_pkg::OP_PASS;             // freed cell comes straight back
        end else if (i_alloc) begin
            op_nxt = heap_pkg::OP_ALLOC;
        end else if (i_free) begin
            op_nxt = heap_pkg::OP_FREE;
        end else if (i_wr && i_rd) begin
            op_nxt = heap_pkg::OP_RW;
        end else if (i_wr) begin
            op_nxt = heap_pkg::OP_WRITE;
        end else if (i_rd) begin
            op_nxt = heap_pkg::OP_READ;
        end else begin
            op_nxt = heap_pkg::OP_NONE;             // idle cycle
        end
    end

    // opcode register
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_cmd.op <= heap_pkg::OP_NONE;
        end else begin
            o_cmd.op <= op_nxt;
        end
    end

    // operands ride along with the opcode
    always_ff @(posedge i_clk) begin
        o_cmd.data  <= i_data;
        o_cmd.addr  <= i_addr;                      // full word becomes head or o_addr
        o_cmd.waddr <= i_waddr[heap_pkg::ADDR_SZ-1:0];  // cell index only
        o_cmd.wdata <= i_wdata;
        o_cmd.raddr <= i_raddr[heap_pkg::ADDR_SZ-1:0];
    end

    // the allocation stage trusts a known opcode every cycle
    a_op_known : assert property (
        @(posedge i_clk) disable iff (i_reset)
        !$isunknown(o_cmd.op)
    ) else $error("heap_decode: opcode register unknown");

endmodule

`default_nettype wire

// File: heap_mem_if.sv
/*
 * heap store bus
 * write, registered data read and combinational link read
 */

`timescale 1ns/1ps
`default_nettype none

interface heap_mem_if;

    logic             we;                           // write strobe
    heap_pkg::index_t widx;                         // write cell
    heap_pkg::word_t  wdata;                        // write data
    logic             re;                           // read strobe
    heap_pkg::index_t ridx;                         // read cell
    heap_pkg::index_t link_idx;                     // free-list head cell
    heap_pkg::word_t  link_data;                    // link stored in head cell

    modport ctl (output we, widx, wdata, re, ridx, link_idx, input link_data);
    modport mem (input we, widx, wdata, re, ridx, link_idx, output link_data);

endinterface

`default_nettype wire

// File: heap_pkg.sv
/*
 * heap package
 * word and cell-index widths, tag bits, reserved word constants
 * and the opcode passed between the heap pipeline stages
 */

`default_nettype none

package heap_pkg;

    // sizes
    localparam int DATA_SZ = 16;                    // bits per tagged word
    localparam int ADDR_SZ = 8;                     // bits per cell index
    localparam int MEM_MAX = 1 << ADDR_SZ;          // cells in the heap

    // tagged word and cell index
    typedef logic [DATA_SZ-1:0] word_t;
    typedef logic [ADDR_SZ-1:0] index_t;

    // type tags
    localparam word_t DIR_TAG = 16'h8000;           // fixnum, else pointer
    localparam word_t MUT_TAG = 16'h4000;           // mutable cell
    localparam word_t OPQ_TAG = 16'h2000;           // opaque capability
    localparam word_t VLT_TAG = 16'h1000;           // volatile cell

    // reserved constants
    localparam word_t UNDEF = 16'h0000;             // no address
    localparam word_t NIL   = 16'h0001;             // empty list, ends the free-list
    localparam word_t TRUE  = 16'h0002;             // boolean true
    localparam word_t FALSE = 16'h0003;             // boolean false
    localparam word_t UNIT  = 16'h0004;             // inert result
    localparam word_t ZERO  = 16'h8000;             // fixnum +0

    // every heap pointer carries this tag pattern
    localparam word_t HEAP_BASE = MUT_TAG | VLT_TAG;

    // decoded request, one per cycle
    typedef enum logic [2:0] {
        OP_NONE,                                    // idle
        OP_ALLOC,                                   // alloc only
        OP_FREE,                                    // free only
        OP_PASS,                                    // alloc and free together
        OP_WRITE,                                   // write only
        OP_READ,                                    // read only
        OP_RW,                                      // write and read together
        OP_CONFLICT                                 // both ports at once
    } heap_op_e;

endpackage

`default_nettype wire

// File: heap_store.sv
/*
 * heap cell store
 * 256 tagged words, one synchronous write, a registered data read
 * and a combinational read of the free-list link
 */

`timescale 1ns/1ps
`default_nettype none

module heap_store (
    input  wire             i_clk,                  // domain clock
    heap_mem_if.mem         i_mem,                  // from allocation stage
    output heap_pkg::word_t o_rdata                 // data read, held between reads
);

    heap_pkg::word_t ram_cell [heap_pkg::MEM_MAX];  // cell array

    // write port
    always_ff @(posedge i_clk) begin
        if (i_mem.we) begin
            ram_cell[i_mem.widx] <= i_mem.wdata;
        end
    end

    // registered data read, old value on same-cycle write
    always_ff @(posedge i_clk) begin
        if (i_mem.re) begin
            o_rdata <= ram_cell[i_mem.ridx];
        end
    end

    // link of the free-list head, needed in the same cycle as the pop
    assign i_mem.link_data = ram_cell[i_mem.link_idx];

    // strobes from the allocation stage must be clean at every edge
    a_strobes_known : assert property (
        @(posedge i_clk)
        !$isunknown({i_mem.we, i_mem.re})
    ) else $error("heap_store: unknown write or read strobe");

endmodule

`default_nettype wire

// File: heap_top.sv
/*
 * linked-memory heap allocator
 * pointer port allocates and frees cells, memory port writes and reads
 * them, three stages with results two edges after the request
 */

`timescale 1ns/1ps
`default_nettype none

module heap_top (
    input  wire             i_clk,                  // domain clock
    input  wire             i_reset,                // sync reset, active high

    // pointer port
    input  wire             i_alloc,                // alloc request
    input  heap_pkg::word_t i_data,                 // initial data
    input  wire             i_free,                 // free request
    input  heap_pkg::word_t i_addr,                 // pointer to free
    output heap_pkg::word_t o_addr,                 // allocated pointer, UNDEF if none

    // memory port
    input  wire             i_wr,                   // write request
    input  heap_pkg::word_t i_waddr,                // write pointer
    input  heap_pkg::word_t i_wdata,                // write data
    input  wire             i_rd,                   // read request
    input  heap_pkg::word_t i_raddr,                // read pointer
    output heap_pkg::word_t o_rdata,                // data read

    output wire             o_err                   // sticky error
);

    heap_cmd_if cmd_bus ();                         // decode -> alloc
    heap_mem_if mem_bus ();                         // alloc -> store

    // stage 1, request decode
    heap_decode u_decode (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_alloc (i_alloc),
        .i_data  (i_data),
        .i_free  (i_free),
        .i_addr  (i_addr),
        .i_wr    (i_wr),
        .i_waddr (i_waddr),
        .i_wdata (i_wdata),
        .i_rd    (i_rd),
        .i_raddr (i_raddr),
        .o_cmd   (cmd_bus.src)
    );

    // stage 2, allocation
    heap_alloc u_alloc (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_cmd   (cmd_bus.dst),
        .o_mem   (mem_bus.ctl),
        .o_addr  (o_addr),
        .o_err   (o_err)
    );

    // stage 3, cell storage
    heap_store u_store (
        .i_clk   (i_clk),
        .i_mem   (mem_bus.mem),
        .o_rdata (o_rdata)
    );

endmodule

`default_nettype wire

// File: tb_heap.sv
/*
 * heap allocator testbench
 * seeded random stimulus on the falling edge through five tests,
 * every result is compared by the checker
 */

`timescale 1ns/1ps
`default_nettype none

module tb_heap;

    localparam int RESET_CYCLES = 16;
    localparam int DRAIN_MAX    = 20;               // cycles allowed for results
    localparam int LIVE_CELLS   = 9;                // cells 0..8 in use after test 2

    logic            clk;
    logic            reset;
    logic            alloc;
    heap_pkg::word_t alloc_data;
    logic            free;
    heap_pkg::word_t free_addr;
    logic            wr;
    heap_pkg::word_t waddr;
    heap_pkg::word_t wdata;
    logic            rd;
    heap_pkg::word_t raddr;
    heap_pkg::word_t ret_addr;
    heap_pkg::word_t rdata;
    logic            err;
    int              chk_issued;
    int              chk_done;
    int              chk_errors;
    int              timeouts;
    int              err_mark;                      // counts at test start
    int              tmo_mark;

    always #50 clk = ~clk;                          // 100 ns period

    heap_top DUT (
        .i_clk (clk), .i_reset (reset),
        .i_alloc (alloc), .i_data (alloc_data), .i_free (free), .i_addr (free_addr),
        .o_addr (ret_addr),
        .i_wr (wr), .i_waddr (waddr), .i_wdata (wdata), .i_rd (rd), .i_raddr (raddr),
        .o_rdata (rdata), .o_err (err)
    );

    heap_checker u_check (
        .i_clk (clk), .i_reset (reset),
        .i_alloc (alloc), .i_data (alloc_data), .i_free (free), .i_addr (free_addr),
        .i_wr (wr), .i_waddr (waddr), .i_wdata (wdata), .i_rd (rd), .i_raddr (raddr),
        .i_ret_addr (ret_addr), .i_rdata (rdata), .i_err (err),
        .o_issued (chk_issued), .o_done (chk_done), .o_errors (chk_errors)
    );

    // reserved constants mixed with random fixnums
    function automatic heap_pkg::word_t rand_word();
        case ($urandom % 5)
            0: return heap_pkg::TRUE;
            1: return heap_pkg::FALSE;
            2: return heap_pkg::UNIT;
            3: return heap_pkg::ZERO;
            default: return heap_pkg::ZERO | heap_pkg::word_t'($urandom % 32768);
        endcase
    endfunction

    task automatic clear_strobes();
        alloc = 1'b0;
        free  = 1'b0;
        wr    = 1'b0;
        rd    = 1'b0;
    endtask

    task automatic apply_reset();
        @(negedge clk);
        clear_strobes();
        reset = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic ptr_req(input logic want_alloc, input logic want_free,
                           input heap_pkg::word_t d, input heap_pkg::index_t idx);
        @(negedge clk);
        clear_strobes();
        alloc      = want_alloc;
        free       = want_free;
        alloc_data = d;
        free_addr  = heap_pkg::HEAP_BASE | heap_pkg::word_t'(idx);  // tagged pointer
    endtask

    task automatic mem_req(input logic want_wr, input logic want_rd, input heap_pkg::index_t w_idx,
                           input heap_pkg::word_t d, input heap_pkg::index_t r_idx);
        @(negedge clk);
        clear_strobes();
        wr    = want_wr;
        rd    = want_rd;
        waddr = heap_pkg::HEAP_BASE | heap_pkg::word_t'(w_idx);
        wdata = d;
        raddr = heap_pkg::HEAP_BASE | heap_pkg::word_t'(r_idx);
    endtask

    // alloc and write in one cycle
    task automatic conflict_req(input heap_pkg::word_t d, input heap_pkg::index_t idx);
        @(negedge clk);
        clear_strobes();
        alloc      = 1'b1;
        alloc_data = d;
        wr         = 1'b1;
        waddr      = heap_pkg::HEAP_BASE | heap_pkg::word_t'(idx);
        wdata      = d;
    endtask

    // idle until the checker has compared every request
    task automatic drain(input string what);
        int n;
        @(negedge clk);
        clear_strobes();
        n = 0;
        @(posedge clk);
        while ((chk_done != chk_issued) && (n < DRAIN_MAX)) begin
            @(posedge clk);
            n++;
        end
        if (chk_done != chk_issued) begin
            $display("timeout: %s did not complete within %0d cycles", what, DRAIN_MAX);
            timeouts++;
        end
    endtask

    task automatic start_test();
        err_mark = chk_errors;
        tmo_mark = timeouts;
    endtask

    task automatic end_test(input int num, input string name);
        int errs;
        int tmo;
        errs = chk_errors - err_mark;
        tmo  = timeouts - tmo_mark;
        if ((errs == 0) && (tmo == 0)) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors, %0d timeouts", num, name, errs, tmo);
        end
    endtask

    initial begin
        heap_pkg::index_t idx;
        int               kind;
        clk        = 1'b0;
        reset      = 1'b1;
        alloc      = 1'b0;
        alloc_data = heap_pkg::UNDEF;
        free       = 1'b0;
        free_addr  = heap_pkg::UNDEF;
        wr         = 1'b0;
        waddr      = heap_pkg::UNDEF;
        wdata      = heap_pkg::UNDEF;
        rd         = 1'b0;
        raddr      = heap_pkg::UNDEF;
        timeouts   = 0;
        void'($urandom(33973));
        apply_reset();

        start_test();
        for (int i = 0; i < 8; i++) begin
            ptr_req(1'b1, 1'b0, rand_word(), '0);   // cells 0..7 from the top
        end
        drain("fresh allocations");
        for (int i = 0; i < 8; i++) begin
            mem_req(1'b0, 1'b1, '0, heap_pkg::UNDEF, heap_pkg::index_t'(i));
        end
        drain("readback of fresh cells");
        end_test(1, "fresh allocations");

        start_test();
        ptr_req(1'b0, 1'b1, heap_pkg::UNDEF, 8'd2);
        ptr_req(1'b0, 1'b1, heap_pkg::UNDEF, 8'd5);
        ptr_req(1'b1, 1'b0, rand_word(), '0);       // newest freed first
        ptr_req(1'b1, 1'b0, rand_word(), '0);
        ptr_req(1'b1, 1'b0, rand_word(), '0);       // list empty, top again
        ptr_req(1'b1, 1'b1, rand_word(), 8'd3);     // alloc and free together
        mem_req(1'b0, 1'b1, '0, heap_pkg::UNDEF, 8'd5);
        mem_req(1'b0, 1'b1, '0, heap_pkg::UNDEF, 8'd2);
        mem_req(1'b0, 1'b1, '0, heap_pkg::UNDEF, 8'd8);
        mem_req(1'b0, 1'b1, '0, heap_pkg::UNDEF, 8'd3);
        drain("free-list reuse");
        end_test(2, "free-list reuse and pass");

        start_test();
        for (int i = 0; i < 48; i++) begin
            idx  = heap_pkg::index_t'($urandom % LIVE_CELLS);
            kind = $urandom % 4;
            case (kind)
                0: mem_req(1'b1, 1'b0, idx, rand_word(), '0);
                1: mem_req(1'b0, 1'b1, '0, heap_pkg::UNDEF, idx);
                2: begin
                    mem_req(1'b1, 1'b0, idx, rand_word(), '0);
                    mem_req(1'b0, 1'b1, '0, heap_pkg::UNDEF, idx);  // read right behind write
                end
                default: mem_req(1'b1, 1'b1, idx, rand_word(),
                                 heap_pkg::index_t'($urandom % LIVE_CELLS));
            endcase
        end
        drain("random writes and reads");
        end_test(3, "random writes and reads");

        start_test();
        conflict_req(rand_word(), 8'd0);
        ptr_req(1'b1, 1'b0, rand_word(), '0);       // halted, no address
        ptr_req(1'b0, 1'b1, heap_pkg::UNDEF, 8'd4);
        ptr_req(1'b1, 1'b0, rand_word(), '0);
        mem_req(1'b1, 1'b1, 8'd1, rand_word(), 8'd1);
        drain("port conflict");
        end_test(4, "port conflict halts the heap");

        start_test();
        apply_reset();
        for (int i = 0; i < heap_pkg::MEM_MAX; i++) begin
            ptr_req(1'b1, 1'b0, rand_word(), '0);   // last one takes index 255
        end
        drain("heap exhaustion");
        end_test(5, "heap exhaustion");

        $display("summary: 5 tests, %0d requests checked, %0d errors, %0d timeouts",
                 chk_done, chk_errors, timeouts);
        if ((chk_errors == 0) && (timeouts == 0)) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
heap_pkg.sv
heap_cmd_if.sv
heap_mem_if.sv
heap_decode.sv
heap_alloc.sv
heap_store.sv
heap_top.sv
heap_checker.sv
tb_heap.sv
